//--- rtl/raycastPkg.sv
`default_nettype none

package raycastPkg;

  // all pose values are signed Q8.8, one map cell = 256 units
  localparam int FRAC_BITS = 8;
  localparam int COORD_W = 16;
  localparam int MAP_SIZE = 16;  // cells per map edge

  // fixed 10 degree rotation step
  localparam logic signed [COORD_W-1:0] COS_ROT = 16'sd252;  // 0.984 after quantizing
  localparam logic signed [COORD_W-1:0] SIN_ROT = 16'sd44;   // 0.172 after quantizing

  // quarter cell per unit of direction
  localparam logic signed [COORD_W-1:0] MOVE_SPEED = 16'sd64;

  // row r, bit c set means cell (c,r) is a wall
  // solid border plus a handful of pillars, row 0 is the leftmost word
  localparam logic [0:MAP_SIZE-1][MAP_SIZE-1:0] WORLD_MAP = {
    16'hFFFF,  // row 0
    16'h8001,
    16'h8001,
    16'h8001,
    16'h8811,  // pillars at columns 4 and 11
    16'h8001,
    16'h8001,
    16'h8001,
    16'h9001,  // pillar at column 12
    16'h8001,
    16'h8101,  // pillar straight ahead of the start pose
    16'h8811,
    16'h8001,
    16'h8001,
    16'h8001,
    16'hFFFF   // row 15
  };

  // spawn in the middle of cell (8,8), looking along +y
  localparam logic signed [COORD_W-1:0] START_POS_X = 16'sd2176;  // 8.5 cells
  localparam logic signed [COORD_W-1:0] START_POS_Y = 16'sd2176;
  localparam logic signed [COORD_W-1:0] START_DIR_X = 16'sd0;
  localparam logic signed [COORD_W-1:0] START_DIR_Y = 16'sd256;    // unit length
  localparam logic signed [COORD_W-1:0] START_PLANE_X = 16'sd169;  // ~0.66, roughly 66 deg fov
  localparam logic signed [COORD_W-1:0] START_PLANE_Y = 16'sd0;

  // one player action per button press
  typedef enum logic [2:0] {
    ACT_NONE  = 3'd0,
    ACT_FWD   = 3'd1,
    ACT_BACK  = 3'd2,
    ACT_LEFT  = 3'd3,
    ACT_RIGHT = 3'd4
  } actionT;

endpackage

`default_nettype wire

//--- rtl/poseIf.sv
`timescale 1ns/10ps
`default_nettype none

// player pose as seen by the renderer side
interface poseIf;

  logic signed [raycastPkg::COORD_W-1:0] posX;    // position, Q8.8 map units
  logic signed [raycastPkg::COORD_W-1:0] posY;
  logic signed [raycastPkg::COORD_W-1:0] dirX;    // view direction, unit length
  logic signed [raycastPkg::COORD_W-1:0] dirY;
  logic signed [raycastPkg::COORD_W-1:0] planeX;  // camera plane, kept perpendicular to dir
  logic signed [raycastPkg::COORD_W-1:0] planeY;

  // controller side owns the registers
  modport ctrl (
    output posX, posY,
    output dirX, dirY,
    output planeX, planeY
  );

  // anything that only looks at the pose
  modport view (
    input posX, posY,
    input dirX, dirY,
    input planeX, planeY
  );

endinterface

`default_nettype wire

//--- rtl/buttonConditioner.sv
`timescale 1ns/10ps
`default_nettype none

module buttonConditioner (
  input  wire                pixel_clk_in,
  input  wire                rst_in,
  input  wire                moveFwd,
  input  wire                moveBack,
  input  wire                rotLeft,
  input  wire                rotRight,
  output raycastPkg::actionT action,
  output logic               actionValid
);

  logic [3:0] rawBtn;   // {right, left, back, fwd}
  logic [3:0] syncA;    // first synchronizer stage
  logic [3:0] syncB;    // second stage, safe to use
  logic [3:0] prevBtn;  // syncB one cycle ago
  logic [3:0] rise;
  raycastPkg::actionT nextAct;

  assign rawBtn = {rotRight, rotLeft, moveBack, moveFwd};

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      syncA   <= '0;
      syncB   <= '0;
      prevBtn <= '0;
    end else begin
      syncA   <= rawBtn;
      syncB   <= syncA;
      prevBtn <= syncB;
    end
  end

  assign rise = syncB & ~prevBtn;  // held buttons stay quiet

  // fixed priority when several go up together
  always_comb begin
    if (rise[0]) nextAct = raycastPkg::ACT_FWD;
    else if (rise[1]) nextAct = raycastPkg::ACT_BACK;
    else if (rise[2]) nextAct = raycastPkg::ACT_LEFT;
    else if (rise[3]) nextAct = raycastPkg::ACT_RIGHT;
    else nextAct = raycastPkg::ACT_NONE;
  end

  // edge register, third stage of the 3 cycle path
  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) actionValid <= 1'b0;
    else actionValid <= |rise;
  end

  always_ff @(posedge pixel_clk_in) begin
    action <= nextAct;  // only meaningful alongside actionValid
  end

  // each edge lasts one cycle, so a press gives an isolated pulse
  apSinglePulse : assert property (@(posedge pixel_clk_in) disable iff (rst_in)
    actionValid |=> !actionValid)
    else $error("actionValid high two cycles in a row");

endmodule

`default_nettype wire

//--- rtl/poseMath.sv
`timescale 1ns/10ps
`default_nettype none

// candidate pose for one action, purely combinational
module poseMath (
  input  wire raycastPkg::actionT                     action,
  input  wire logic signed [raycastPkg::COORD_W-1:0] posX,
  input  wire logic signed [raycastPkg::COORD_W-1:0] posY,
  input  wire logic signed [raycastPkg::COORD_W-1:0] dirX,
  input  wire logic signed [raycastPkg::COORD_W-1:0] dirY,
  input  wire logic signed [raycastPkg::COORD_W-1:0] planeX,
  input  wire logic signed [raycastPkg::COORD_W-1:0] planeY,
  output logic signed [raycastPkg::COORD_W-1:0]      candPosX,
  output logic signed [raycastPkg::COORD_W-1:0]      candPosY,
  output logic signed [raycastPkg::COORD_W-1:0]      candDirX,
  output logic signed [raycastPkg::COORD_W-1:0]      candDirY,
  output logic signed [raycastPkg::COORD_W-1:0]      candPlaneX,
  output logic signed [raycastPkg::COORD_W-1:0]      candPlaneY,
  output logic [3:0]                                 cellX,
  output logic [3:0]                                 cellY,
  output logic                                       outOfMap
);

  logic signed [31:0] cosK;   // constants widened for 32 bit products
  logic signed [31:0] sinK;   // +sin turning left, -sin turning right
  logic signed [31:0] moveK;
  logic signed [raycastPkg::COORD_W-1:0] stepX;  // dir scaled by move speed
  logic signed [raycastPkg::COORD_W-1:0] stepY;
  logic signed [raycastPkg::COORD_W-1:0] cellFullX;  // integer part, sign kept
  logic signed [raycastPkg::COORD_W-1:0] cellFullY;

  // drop the extra fraction bits of a Q16.16 product, floor toward -inf
  function automatic logic signed [raycastPkg::COORD_W-1:0] toQ88(
    input logic signed [31:0] acc
  );
    logic signed [31:0] shifted;
    shifted = acc >>> raycastPkg::FRAC_BITS;
    return shifted[raycastPkg::COORD_W-1:0];
  endfunction

  assign cosK  = 32'(raycastPkg::COS_ROT);
  assign sinK  = (action == raycastPkg::ACT_RIGHT) ? -32'(raycastPkg::SIN_ROT)
                                                  : 32'(raycastPkg::SIN_ROT);
  assign moveK = 32'(raycastPkg::MOVE_SPEED);

  assign stepX = toQ88(dirX * moveK);
  assign stepY = toQ88(dirY * moveK);

  always_comb begin
    candPosX   = posX;  // no action -> pose passes through
    candPosY   = posY;
    candDirX   = dirX;
    candDirY   = dirY;
    candPlaneX = planeX;
    candPlaneY = planeY;
    case (action)
      raycastPkg::ACT_FWD: begin
        candPosX = posX + stepX;
        candPosY = posY + stepY;
      end
      raycastPkg::ACT_BACK: begin
        candPosX = posX - stepX;
        candPosY = posY - stepY;
      end
      raycastPkg::ACT_LEFT, raycastPkg::ACT_RIGHT: begin
        // same rotation matrix for dir and plane so they stay perpendicular
        candDirX   = toQ88(dirX * cosK + dirY * sinK);
        candDirY   = toQ88(dirY * cosK - dirX * sinK);
        candPlaneX = toQ88(planeX * cosK + planeY * sinK);
        candPlaneY = toQ88(planeY * cosK - planeX * sinK);
      end
      default: ;
    endcase
  end

  // target cell of the candidate position
  assign cellFullX = candPosX >>> raycastPkg::FRAC_BITS;
  assign cellFullY = candPosY >>> raycastPkg::FRAC_BITS;
  assign cellX = cellFullX[3:0];
  assign cellY = cellFullY[3:0];

  assign outOfMap = (cellFullX < 0) || (cellFullX >= raycastPkg::MAP_SIZE) ||
                    (cellFullY < 0) || (cellFullY >= raycastPkg::MAP_SIZE);

endmodule

`default_nettype wire

//--- rtl/playerController.sv
`timescale 1ns/10ps
`default_nettype none

module playerController (
  input  wire                pixel_clk_in,
  input  wire                rst_in,
  input  wire raycastPkg::actionT action,
  input  wire                actionValid,
  poseIf.ctrl                pose,
  output logic               busy,
  output logic               bump   // one cycle, move refused
);

  // DONE holds busy one more cycle after the commit so bump lands inside busy
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    EVAL  = 2'd1,
    CHECK = 2'd2,
    DONE  = 2'd3
  } stateT;

  stateT state;
  raycastPkg::actionT actReg;  // action being worked on

  // combinational candidate from poseMath
  logic signed [raycastPkg::COORD_W-1:0] candPosX, candPosY;
  logic signed [raycastPkg::COORD_W-1:0] candDirX, candDirY;
  logic signed [raycastPkg::COORD_W-1:0] candPlaneX, candPlaneY;
  logic [3:0] cellX, cellY;
  logic outOfMap;

  // registered copy, taken in EVAL
  logic signed [raycastPkg::COORD_W-1:0] heldPosX, heldPosY;
  logic signed [raycastPkg::COORD_W-1:0] heldDirX, heldDirY;
  logic signed [raycastPkg::COORD_W-1:0] heldPlaneX, heldPlaneY;
  logic [3:0] heldCellX, heldCellY;
  logic heldOut;

  logic isRot;
  logic wallHit;

  poseMath uMath (
    .action     (actReg),
    .posX       (pose.posX),
    .posY       (pose.posY),
    .dirX       (pose.dirX),
    .dirY       (pose.dirY),
    .planeX     (pose.planeX),
    .planeY     (pose.planeY),
    .candPosX   (candPosX),
    .candPosY   (candPosY),
    .candDirX   (candDirX),
    .candDirY   (candDirY),
    .candPlaneX (candPlaneX),
    .candPlaneY (candPlaneY),
    .cellX      (cellX),
    .cellY      (cellY),
    .outOfMap   (outOfMap)
  );

  assign busy    = (state != IDLE);
  assign isRot   = (actReg == raycastPkg::ACT_LEFT) || (actReg == raycastPkg::ACT_RIGHT);
  assign wallHit = raycastPkg::WORLD_MAP[heldCellY][heldCellX];  // bit per cell

  always_ff @(posedge pixel_clk_in) begin
    if (state == IDLE && actionValid) actReg <= action;  // ignored while busy
    if (state == EVAL) begin
      heldPosX   <= candPosX;
      heldPosY   <= candPosY;
      heldDirX   <= candDirX;
      heldDirY   <= candDirY;
      heldPlaneX <= candPlaneX;
      heldPlaneY <= candPlaneY;
      heldCellX  <= cellX;
      heldCellY  <= cellY;
      heldOut    <= outOfMap;
    end
  end

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      state       <= IDLE;
      bump        <= 1'b0;
      pose.posX   <= raycastPkg::START_POS_X;
      pose.posY   <= raycastPkg::START_POS_Y;
      pose.dirX   <= raycastPkg::START_DIR_X;
      pose.dirY   <= raycastPkg::START_DIR_Y;
      pose.planeX <= raycastPkg::START_PLANE_X;
      pose.planeY <= raycastPkg::START_PLANE_Y;
    end else begin
      bump <= 1'b0;
      case (state)
        IDLE:  if (actionValid) state <= EVAL;
        EVAL:  state <= CHECK;
        CHECK: begin
          state <= DONE;
          // rotations never leave the cell, moves must land on open floor
          if (isRot || (!heldOut && !wallHit)) begin
            pose.posX   <= heldPosX;
            pose.posY   <= heldPosY;
            pose.dirX   <= heldDirX;
            pose.dirY   <= heldDirY;
            pose.planeX <= heldPlaneX;
            pose.planeY <= heldPlaneY;
          end else begin
            bump <= 1'b1;
          end
        end
        DONE:    state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // a press during a running sequence must not restart or retarget it
  apDropWhileBusy : assert property (@(posedge pixel_clk_in) disable iff (rst_in)
    (busy && actionValid) |=> ($stable(actReg) && state != EVAL))
    else $error("action accepted while busy");

  // the wall check upstream keeps the player out of solid cells
  apNotInWall : assert property (@(posedge pixel_clk_in) disable iff (rst_in)
    !raycastPkg::WORLD_MAP[pose.posY[raycastPkg::FRAC_BITS +: 4]]
                          [pose.posX[raycastPkg::FRAC_BITS +: 4]])
    else $error("committed position inside a wall cell");

endmodule

`default_nettype wire

//--- rtl/raycastControlTop.sv
`timescale 1ns/10ps
`default_nettype none

module raycastControlTop (
  input  wire                                 pixel_clk_in,
  input  wire                                 rst_in,
  input  wire                                 moveFwd,
  input  wire                                 moveBack,
  input  wire                                 rotLeft,
  input  wire                                 rotRight,
  output logic signed [raycastPkg::COORD_W-1:0] posX,
  output logic signed [raycastPkg::COORD_W-1:0] posY,
  output logic signed [raycastPkg::COORD_W-1:0] dirX,
  output logic signed [raycastPkg::COORD_W-1:0] dirY,
  output logic signed [raycastPkg::COORD_W-1:0] planeX,
  output logic signed [raycastPkg::COORD_W-1:0] planeY,
  output logic                                busy,
  output logic                                bump
);

  raycastPkg::actionT action;
  logic actionValid;  // single cycle, 3 cycles after the pin edge

  poseIf poseBus ();

  buttonConditioner uButtons (
    .pixel_clk_in (pixel_clk_in),
    .rst_in       (rst_in),
    .moveFwd      (moveFwd),
    .moveBack     (moveBack),
    .rotLeft      (rotLeft),
    .rotRight     (rotRight),
    .action       (action),
    .actionValid  (actionValid)
  );

  playerController uCtrl (
    .pixel_clk_in (pixel_clk_in),
    .rst_in       (rst_in),
    .action       (action),
    .actionValid  (actionValid),
    .pose         (poseBus.ctrl),
    .busy         (busy),
    .bump         (bump)
  );

  // read-only view of the pose, flattened for the renderer
  assign posX   = poseBus.posX;
  assign posY   = poseBus.posY;
  assign dirX   = poseBus.dirX;
  assign dirY   = poseBus.dirY;
  assign planeX = poseBus.planeX;
  assign planeY = poseBus.planeY;

endmodule

`default_nettype wire

//--- tb/tbRaycastControl.sv
`timescale 1ns/10ps
`default_nettype none

module tbRaycastControl;

  localparam int MAX_HOLD = 30;  // longest hold, used by the held-button case
  localparam int MAX_GAP = 6;    // idle cycles after a press
  localparam int PRESS_SPAN = MAX_HOLD + 10 + MAX_GAP;  // worst case start to next start
  localparam int PLANNED_PRESSES = 40 + 36 + 20 + 8 + 14 + 4;
  localparam int TIMEOUT_LIMIT = PLANNED_PRESSES * PRESS_SPAN + 200;

  logic pixel_clk_in;
  logic rst_in;
  logic [3:0] btns;  // {right, left, back, fwd}
  logic signed [raycastPkg::COORD_W-1:0] posX, posY, dirX, dirY, planeX, planeY;
  logic busy;
  logic bump;

  logic signed [raycastPkg::COORD_W-1:0] mPose [6];    // model pose, posX..planeY
  logic signed [raycastPkg::COORD_W-1:0] oldPose [6];  // model pose before the press
  int errorCount;
  int checkCount;
  int testCount;
  int testStartErrors;
  int cycles;
  int bumpTotal;  // bump pulses seen at the DUT

  raycastControlTop uut (
    .pixel_clk_in (pixel_clk_in),
    .rst_in       (rst_in),
    .moveFwd      (btns[0]),
    .moveBack     (btns[1]),
    .rotLeft      (btns[2]),
    .rotRight     (btns[3]),
    .posX         (posX),
    .posY         (posY),
    .dirX         (dirX),
    .dirY         (dirY),
    .planeX       (planeX),
    .planeY       (planeY),
    .busy         (busy),
    .bump         (bump)
  );

  always #10 pixel_clk_in = ~pixel_clk_in;  // 20 ns period

  always @(posedge pixel_clk_in) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_LIMIT);
      $display("Errors found");
      $finish;
    end
  end

  task automatic checkValue(input string name, input logic [15:0] expected,
                            input logic [15:0] actual);
    checkCount++;
    if (expected !== actual) begin
      errorCount++;
      $display("mismatch %s: expected 0x%h, actual 0x%h", name, expected, actual);
    end
  endtask

  function automatic string poseName(input int idx);
    case (idx)
      0: return "posX";
      1: return "posY";
      2: return "dirX";
      3: return "dirY";
      4: return "planeX";
      default: return "planeY";
    endcase
  endfunction

  function automatic logic [15:0] dutValue(input int idx);
    case (idx)
      0: return posX;
      1: return posY;
      2: return dirX;
      3: return dirY;
      4: return planeX;
      default: return planeY;
    endcase
  endfunction

  // all six outputs against the model, before or after the running press
  task automatic comparePose(input string when, input bit useNew);
    logic [15:0] expected;
    for (int i = 0; i < 6; i++) begin
      expected = useNew ? mPose[i] : oldPose[i];
      checkValue({when, " ", poseName(i)}, expected, dutValue(i));
    end
  endtask

  task automatic resetDut();
    @(posedge pixel_clk_in);
    rst_in <= 1'b1;
    btns <= 4'b0;
    repeat (5) @(posedge pixel_clk_in);
    rst_in <= 1'b0;
    mPose[0] = raycastPkg::START_POS_X;
    mPose[1] = raycastPkg::START_POS_Y;
    mPose[2] = raycastPkg::START_DIR_X;
    mPose[3] = raycastPkg::START_DIR_Y;
    mPose[4] = raycastPkg::START_PLANE_X;
    mPose[5] = raycastPkg::START_PLANE_Y;
  endtask

  // fwd beats back beats left beats right
  function automatic raycastPkg::actionT maskToAction(input logic [3:0] mask);
    if (mask[0]) return raycastPkg::ACT_FWD;
    if (mask[1]) return raycastPkg::ACT_BACK;
    if (mask[2]) return raycastPkg::ACT_LEFT;
    if (mask[3]) return raycastPkg::ACT_RIGHT;
    return raycastPkg::ACT_NONE;
  endfunction

  // reference pose update, Q8.8 with every product floored by >>> 8
  task automatic applyAction(input logic [3:0] mask, output logic refused);
    raycastPkg::actionT act;
    int stepX, stepY, tx, ty, cx, cy, c, s, x, y, v;
    act = maskToAction(mask);
    refused = 1'b0;
    c = int'(raycastPkg::COS_ROT);
    s = (act == raycastPkg::ACT_RIGHT) ? -int'(raycastPkg::SIN_ROT)
                                       : int'(raycastPkg::SIN_ROT);
    if (act == raycastPkg::ACT_FWD || act == raycastPkg::ACT_BACK) begin
      stepX = (int'(mPose[2]) * int'(raycastPkg::MOVE_SPEED)) >>> raycastPkg::FRAC_BITS;
      stepY = (int'(mPose[3]) * int'(raycastPkg::MOVE_SPEED)) >>> raycastPkg::FRAC_BITS;
      if (act == raycastPkg::ACT_BACK) begin
        stepX = -stepX;  // pos minus the truncated step
        stepY = -stepY;
      end
      tx = int'(mPose[0]) + stepX;
      ty = int'(mPose[1]) + stepY;
      cx = tx >>> raycastPkg::FRAC_BITS;  // target cell
      cy = ty >>> raycastPkg::FRAC_BITS;
      if (cx < 0 || cx >= raycastPkg::MAP_SIZE || cy < 0 || cy >= raycastPkg::MAP_SIZE)
        refused = 1'b1;
      else if (raycastPkg::WORLD_MAP[cy][cx])
        refused = 1'b1;
      if (!refused) begin
        mPose[0] = 16'(tx);
        mPose[1] = 16'(ty);
      end
    end else if (act != raycastPkg::ACT_NONE) begin
      for (v = 2; v <= 4; v += 2) begin  // dir pair, then plane pair
        x = int'(mPose[v]);
        y = int'(mPose[v+1]);
        mPose[v] = 16'((x * c + y * s) >>> raycastPkg::FRAC_BITS);
        mPose[v+1] = 16'((y * c - x * s) >>> raycastPkg::FRAC_BITS);
      end
    end
  endtask

  // one press at the pins, optional second button while busy, then a random gap
  task automatic runPress(input logic [3:0] mask, input int hold,
                          input logic [3:0] extraMask, input int extraAt);
    logic refused;
    logic prevBusy;
    bit done;
    int k, busyRiseAt, busyCycles, busyRises, bumpCount;
    oldPose = mPose;
    applyAction(mask, refused);
    k = 0;
    busyRiseAt = -1;
    busyCycles = 0;
    busyRises = 0;
    bumpCount = 0;
    prevBusy = 1'b0;
    done = 0;
    @(posedge pixel_clk_in);
    btns <= mask;  // pin edge, k = 0
    while (!done) begin
      @(posedge pixel_clk_in);
      k++;
      if (k == extraAt) btns <= mask | extraMask;
      if (k == hold) btns <= 4'b0;
      @(negedge pixel_clk_in);  // outputs settled here
      if (busy && !prevBusy) begin
        busyRises++;
        if (busyRiseAt < 0) busyRiseAt = k;
      end
      if (busy) busyCycles++;
      if (bump) bumpCount++;
      if (k == 5) comparePose("before commit", 0);
      if (k == 6) comparePose("after commit", 1);  // 6 cycles from the pin edge
      prevBusy = busy;
      if (k > hold && !busy && (busyRises > 0 || k > 12)) done = 1;
    end
    bumpTotal += bumpCount;
    checkValue("busy rise cycle", 16'(4), 16'(busyRiseAt));
    checkValue("busy cycles", 16'(3), 16'(busyCycles));
    checkValue("busy pulses", 16'(1), 16'(busyRises));
    checkValue("bump pulses", 16'(refused), 16'(bumpCount));
    repeat ($urandom_range(0, MAX_GAP)) @(posedge pixel_clk_in);
  endtask

  task automatic startTest();
    testStartErrors = errorCount;
  endtask

  task automatic finishTest(input string name);
    testCount++;
    $display("test %0d %s: %0d errors", testCount, name, errorCount - testStartErrors);
  endtask

  initial begin
    logic [3:0] mask;
    int a;
    pixel_clk_in = 1'b0;
    rst_in = 1'b1;
    btns = 4'b0;
    errorCount = 0;
    checkCount = 0;
    testCount = 0;
    cycles = 0;
    bumpTotal = 0;
    void'($urandom(99));
    resetDut();

    startTest();
    @(negedge pixel_clk_in);
    comparePose("reset", 1);
    checkValue("busy", 16'(0), 16'(busy));
    checkValue("bump", 16'(0), 16'(bump));
    finishTest("reset state");

    startTest();
    repeat (40) runPress($urandom_range(0, 1) ? 4'b0100 : 4'b1000,
                         $urandom_range(1, 8), 4'b0, 0);
    repeat (36) runPress(4'b0100, $urandom_range(1, 8), 4'b0, 0);  // full turn left
    finishTest("rotations");

    startTest();
    resetDut();
    repeat (20) runPress($urandom_range(0, 1) ? 4'b0001 : 4'b0010,
                         $urandom_range(1, 8), 4'b0, 0);
    finishTest("forward and back");

    startTest();
    resetDut();
    bumpTotal = 0;
    repeat (8) runPress(4'b0001, $urandom_range(1, 8), 4'b0, 0);  // pillar at cell (8,10)
    if (bumpTotal == 0) begin
      errorCount++;
      $display("walking into the pillar never raised bump");
    end
    finishTest("wall bump");

    startTest();
    repeat (6) begin
      a = $urandom_range(0, 3);
      runPress(4'(1 << a), $urandom_range(4, 8),
               4'(1 << ((a + $urandom_range(1, 3)) % 4)), $urandom_range(2, 3));
    end
    repeat (6) begin
      mask = 4'($urandom_range(3, 15));
      while ($countones(mask) < 2) mask = 4'($urandom_range(3, 15));
      runPress(mask, $urandom_range(1, 8), 4'b0, 0);
    end
    repeat (2) runPress(4'(1 << $urandom_range(0, 3)), MAX_HOLD, 4'b0, 0);
    finishTest("busy, priority and held buttons");

    startTest();
    repeat (4) runPress(4'(1 << $urandom_range(0, 3)), $urandom_range(1, 3), 4'b0, 0);
    finishTest("handshake timing");

    $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
rtl/raycastPkg.sv
rtl/poseIf.sv
rtl/buttonConditioner.sv
rtl/poseMath.sv
rtl/playerController.sv
rtl/raycastControlTop.sv
tb/tbRaycastControl.sv

//--- Makefile
# Verilator build of the player-control testbench

SRCS := $(wildcard rtl/*.sv) $(wildcard tb/*.sv)
BIN := obj_dir/VtbRaycastControl

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): compile.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module tbRaycastControl -f compile.f

# exit status follows the pass message in the simulator output
run: $(BIN)
	./$(BIN) | awk '{ print } /^No errors$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
